// ==== mvb2mfb.f ====
design/mvb2mfb_pkg.sv
design/item_lane_if.sv
design/mvb_item_queue.sv
design/mfb_frame_assembler.sv
design/mvb2mfb.sv
test/mvb2mfb_checker.sv
test/mvb2mfb_tb.sv

// ==== Makefile ====
# Verilator build for the MVB to MFB converter
# usage: make lint | make sim | make clean

VERILATOR ?= verilator
FILELIST  ?= mvb2mfb.f
RTL_TOP   ?= mvb2mfb
TB_TOP    ?= mvb2mfb_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# the run passes only if the pass message shows up as a line of its own
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/mvb2mfb_tb.sv ====
// MVB to MFB converter testbench
// LFSR driven MVB words, random output back-pressure and an expected-item model
`timescale 1ns/10ps
`default_nettype none

module mvb2mfb_tb;

    import mvb2mfb_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 6;
    localparam int DRAIN_QUIET  = 8;
    localparam int FULL_WORDS   = 40;
    localparam int RAND_WORDS   = 60;
    localparam int BP_WORDS     = 60;
    localparam int TOTAL_WORDS  = FULL_WORDS + RAND_WORDS + BP_WORDS;
    localparam int CYCLE_LIMIT  = 4 * TOTAL_WORDS + 200;

    logic                              CLK;
    logic                              rst;
    logic [MVB_ITEMS*item_width-1:0]   rx_mvb_data;
    logic [MVB_ITEMS*META_WIDTH-1:0]   rx_mvb_meta;
    logic [MVB_ITEMS-1:0]              rx_mvb_vld;
    logic                              rx_mvb_src_rdy;
    logic                              rx_mvb_dst_rdy;
    logic [MFB_REGIONS*item_width-1:0] tx_mfb_data;
    logic [MFB_REGIONS*META_WIDTH-1:0] tx_mfb_meta;
    logic [MFB_REGIONS*sof_pos_width-1:0] tx_mfb_sof_pos;
    logic [MFB_REGIONS*eof_pos_width-1:0] tx_mfb_eof_pos;
    logic [MFB_REGIONS-1:0]            tx_mfb_sof;
    logic [MFB_REGIONS-1:0]            tx_mfb_eof;
    logic                              tx_mfb_src_rdy;
    logic                              tx_mfb_dst_rdy;

    logic [31:0] lfsr_state;
    int          chk_errors;
    int          chk_items;
    int          tb_errors    = 0;
    int          tests_failed = 0;
    int          err_mark;
    int          item_mark;
    int          cycles       = 0;

    mvb2mfb #(
        .MVB_ITEMS       (MVB_ITEMS),
        .MFB_REGIONS     (MFB_REGIONS),
        .MFB_REGION_SIZE (MFB_REGION_SIZE),
        .MFB_BLOCK_SIZE  (MFB_BLOCK_SIZE),
        .MFB_ITEM_WIDTH  (MFB_ITEM_WIDTH),
        .META_WIDTH      (META_WIDTH)
    ) DUT (
        .CLK (CLK), .rst (rst),
        .rx_mvb_data (rx_mvb_data), .rx_mvb_meta (rx_mvb_meta), .rx_mvb_vld (rx_mvb_vld),
        .rx_mvb_src_rdy (rx_mvb_src_rdy), .rx_mvb_dst_rdy (rx_mvb_dst_rdy),
        .tx_mfb_data (tx_mfb_data), .tx_mfb_meta (tx_mfb_meta),
        .tx_mfb_sof_pos (tx_mfb_sof_pos), .tx_mfb_eof_pos (tx_mfb_eof_pos),
        .tx_mfb_sof (tx_mfb_sof), .tx_mfb_eof (tx_mfb_eof),
        .tx_mfb_src_rdy (tx_mfb_src_rdy), .tx_mfb_dst_rdy (tx_mfb_dst_rdy)
    );

    mvb2mfb_checker frame_check (
        .CLK (CLK), .rst (rst),
        .tx_mfb_data (tx_mfb_data), .tx_mfb_meta (tx_mfb_meta),
        .tx_mfb_sof_pos (tx_mfb_sof_pos), .tx_mfb_eof_pos (tx_mfb_eof_pos),
        .tx_mfb_sof (tx_mfb_sof), .tx_mfb_eof (tx_mfb_eof),
        .tx_mfb_src_rdy (tx_mfb_src_rdy), .tx_mfb_dst_rdy (tx_mfb_dst_rdy),
        .error_count (chk_errors), .item_count (chk_items)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // =========================================================================
    // random bits
    // =========================================================================
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int total_errors();
        return tb_errors + chk_errors;
    endfunction

    task automatic report_mismatch(input string msg);
        tb_errors++;
        $display("FAILED at %0d ns: %s", $time, msg);
    endtask

    // every accepted word adds its valid items in index order
    always @(posedge CLK) begin : model_inputs
        if (!rst && rx_mvb_src_rdy && rx_mvb_dst_rdy) begin
            for (int i = 0; i < MVB_ITEMS; i++) begin
                if (rx_mvb_vld[i]) begin
                    frame_check.push_expected(rx_mvb_data[i*item_width +: item_width],
                                              rx_mvb_meta[i*META_WIDTH +: META_WIDTH]);
                end
            end
        end
    end

    always @(posedge CLK) begin : watchdog
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    // =========================================================================
    // stimulus tasks
    // =========================================================================
    task automatic send_word(input logic [MVB_ITEMS-1:0] mask, input bit random_src,
                             input bit random_bp);
        logic accepted;
        accepted = 1'b0;
        @(negedge CLK);
        for (int i = 0; i < MVB_ITEMS; i++) begin
            rx_mvb_data[i*item_width +: item_width] = item_width'(rand_bits(item_width));
            rx_mvb_meta[i*META_WIDTH +: META_WIDTH] = META_WIDTH'(rand_bits(META_WIDTH));
        end
        rx_mvb_vld = mask;
        while (!accepted) begin
            rx_mvb_src_rdy = random_src ? (rand_bits(2) != 0) : 1'b1;
            tx_mfb_dst_rdy = random_bp ? (rand_bits(1) != 0) : 1'b1;
            @(posedge CLK);
            accepted = rx_mvb_src_rdy && rx_mvb_dst_rdy;
            if (!accepted) begin
                @(negedge CLK);
            end
        end
    endtask

    // idle input until the output stays quiet, then look for leftovers
    task automatic drain_dut();
        int quiet;
        int leftover;
        quiet = 0;
        @(negedge CLK);
        rx_mvb_src_rdy = 1'b0;
        rx_mvb_vld     = '0;
        tx_mfb_dst_rdy = 1'b1;
        while (quiet < DRAIN_QUIET) begin
            @(negedge CLK);
            quiet = tx_mfb_src_rdy ? 0 : quiet + 1;
        end
        leftover = frame_check.flush_expected();
        if (leftover != 0) begin
            tb_errors++;
            $display("%0d expected items never came out of the DUT", leftover);
        end
    endtask

    task automatic begin_test();
        err_mark  = total_errors();
        item_mark = chk_items;
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        drain_dut();
        errs = total_errors() - err_mark;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d items checked, %0d errors", num, name,
                 chk_items - item_mark, errs);
    endtask

    task automatic check_reset();
        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            if (tx_mfb_src_rdy !== 1'b0) begin
                report_mismatch("tx_mfb_src_rdy not low during reset");
            end
        end
        rst = 1'b0;
        repeat (IDLE_CYCLES) begin
            @(negedge CLK);
            if (tx_mfb_src_rdy !== 1'b0) begin
                report_mismatch("tx_mfb_src_rdy high before any input");
            end
            if (rx_mvb_dst_rdy !== 1'b1) begin
                report_mismatch("rx_mvb_dst_rdy low after reset");
            end
        end
    endtask

    // =========================================================================
    // test sequence
    // =========================================================================
    initial begin : main
        logic [MVB_ITEMS-1:0] mask;
        CLK            = 1'b0;
        rst            = 1'b1;
        rx_mvb_data    = '0;
        rx_mvb_meta    = '0;
        rx_mvb_vld     = '0;
        rx_mvb_src_rdy = 1'b0;
        tx_mfb_dst_rdy = 1'b1;
        lfsr_state     = 32'hcaed;

        begin_test();
        check_reset();
        end_test(1, "after reset");

        begin_test();
        for (int w = 0; w < FULL_WORDS; w++) begin
            send_word('1, 1'b0, 1'b0);
        end
        end_test(2, "full words");

        // every tenth word is forced empty
        begin_test();
        for (int w = 0; w < RAND_WORDS; w++) begin
            mask = (w % 10 == 0) ? '0 : MVB_ITEMS'(rand_bits(MVB_ITEMS));
            send_word(mask, 1'b1, 1'b0);
        end
        end_test(3, "random valid masks");

        begin_test();
        for (int w = 0; w < BP_WORDS; w++) begin
            mask = MVB_ITEMS'(rand_bits(MVB_ITEMS));
            send_word(mask, 1'b1, 1'b1);
        end
        end_test(4, "output back-pressure");

        $display("summary: 4 tests, %0d failed, %0d items checked, %0d errors",
                 tests_failed, chk_items, total_errors());
        if (total_errors() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/mvb2mfb_checker.sv ====
// MVB to MFB converter frame checker
// compares every transferred MFB frame with the expected item queue
`timescale 1ns/10ps
`default_nettype none

module mvb2mfb_checker (
    input  wire logic CLK,
    input  wire logic rst,
    input  wire logic [mvb2mfb_pkg::MFB_REGIONS*mvb2mfb_pkg::item_width-1:0]    tx_mfb_data,
    input  wire logic [mvb2mfb_pkg::MFB_REGIONS*mvb2mfb_pkg::META_WIDTH-1:0]    tx_mfb_meta,
    input  wire logic [mvb2mfb_pkg::MFB_REGIONS*mvb2mfb_pkg::sof_pos_width-1:0] tx_mfb_sof_pos,
    input  wire logic [mvb2mfb_pkg::MFB_REGIONS*mvb2mfb_pkg::eof_pos_width-1:0] tx_mfb_eof_pos,
    input  wire logic [mvb2mfb_pkg::MFB_REGIONS-1:0]                            tx_mfb_sof,
    input  wire logic [mvb2mfb_pkg::MFB_REGIONS-1:0]                            tx_mfb_eof,
    input  wire logic                                                           tx_mfb_src_rdy,
    input  wire logic                                                           tx_mfb_dst_rdy,
    output int                                                                  error_count,
    output int                                                                  item_count
);

    import mvb2mfb_pkg::*;

    localparam int SOF_W    = sof_pos_width;
    localparam int EOF_W    = eof_pos_width;
    localparam int LAST_POS = MFB_REGION_SIZE * MFB_BLOCK_SIZE - 1;

    // expected items, oldest first
    logic [item_width-1:0] exp_data [$];
    logic [META_WIDTH-1:0] exp_meta [$];

    int errors = 0;
    int items  = 0;

    logic                              held = 1'b0;
    logic [MFB_REGIONS*item_width-1:0] held_data;
    logic [MFB_REGIONS*META_WIDTH-1:0] held_meta;
    logic [MFB_REGIONS-1:0]            held_sof;

    assign error_count = errors;
    assign item_count  = items;

    task automatic push_expected(input logic [item_width-1:0] data,
                                 input logic [META_WIDTH-1:0] meta);
        exp_data.push_back(data);
        exp_meta.push_back(meta);
    endtask

    // empties the queue and says how many items were still waiting
    function automatic int flush_expected();
        int n;
        n = exp_data.size();
        exp_data.delete();
        exp_meta.delete();
        return n;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("FAILED at %0d ns: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // =========================================================================
    // one transferred MFB word
    // =========================================================================
    task automatic check_word();
        logic [item_width-1:0] got_data;
        logic [item_width-1:0] want_data;
        logic [META_WIDTH-1:0] got_meta;
        logic [META_WIDTH-1:0] want_meta;
        if (tx_mfb_sof == '0) begin
            report_problem($sformatf("an MFB word at %0d ns carried no frame", $time));
        end
        for (int r = 0; r < MFB_REGIONS; r++) begin
            if (tx_mfb_sof[r] !== tx_mfb_eof[r]) begin
                report_mismatch($sformatf("region %0d sof and eof differ", r));
            end
            if (tx_mfb_sof[r]) begin
                got_data = tx_mfb_data[r*item_width +: item_width];
                got_meta = tx_mfb_meta[r*META_WIDTH +: META_WIDTH];
                if (tx_mfb_sof_pos[r*SOF_W +: SOF_W] !== '0) begin
                    report_mismatch($sformatf("region %0d start position not 0", r));
                end
                if (tx_mfb_eof_pos[r*EOF_W +: EOF_W] !== EOF_W'(LAST_POS)) begin
                    report_mismatch($sformatf("region %0d end position not %0d", r, LAST_POS));
                end
                if (exp_data.size() == 0) begin
                    report_problem($sformatf(
                        "region %0d at %0d ns carried a frame with no input item left to match",
                        r, $time));
                end else begin
                    want_data = exp_data.pop_front();
                    want_meta = exp_meta.pop_front();
                    items++;
                    if (got_data !== want_data) begin
                        report_mismatch($sformatf("region %0d data %h, expected %h",
                                                  r, got_data, want_data));
                    end
                    if (got_meta !== want_meta) begin
                        report_mismatch($sformatf("region %0d meta %h, expected %h",
                                                  r, got_meta, want_meta));
                    end
                end
            end
        end
    endtask

    // =========================================================================
    // output port watch
    // =========================================================================
    always @(posedge CLK) begin : watch_output
        if (rst) begin
            held = 1'b0;
            if (tx_mfb_src_rdy === 1'b1) begin
                report_mismatch("tx_mfb_src_rdy high during reset");
            end
        end else begin
            // a stalled word must come back unchanged
            if (held && !tx_mfb_src_rdy) begin
                report_mismatch("output word withdrawn while tx_mfb_dst_rdy was low");
            end else if (held && (tx_mfb_data !== held_data || tx_mfb_meta !== held_meta
                                  || tx_mfb_sof !== held_sof)) begin
                report_mismatch("held output word changed while tx_mfb_dst_rdy was low");
            end
            held      = tx_mfb_src_rdy && !tx_mfb_dst_rdy;
            held_data = tx_mfb_data;
            held_meta = tx_mfb_meta;
            held_sof  = tx_mfb_sof;
            if (tx_mfb_src_rdy && tx_mfb_dst_rdy) begin
                check_word();
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/mvb2mfb.sv ====
// MVB to MFB converter top level
// two item queues (data and metadata) feeding one frame assembler
`timescale 1ns/10ps
`default_nettype none

module mvb2mfb #(
    parameter int   MVB_ITEMS       = mvb2mfb_pkg::MVB_ITEMS,
    parameter int   MFB_REGIONS     = mvb2mfb_pkg::MFB_REGIONS,
    parameter int   MFB_REGION_SIZE = mvb2mfb_pkg::MFB_REGION_SIZE,
    parameter int   MFB_BLOCK_SIZE  = mvb2mfb_pkg::MFB_BLOCK_SIZE,
    parameter int   MFB_ITEM_WIDTH  = mvb2mfb_pkg::MFB_ITEM_WIDTH,
    parameter int   META_WIDTH      = mvb2mfb_pkg::META_WIDTH,
    localparam int  ITEM_W          = MFB_REGION_SIZE * MFB_BLOCK_SIZE * MFB_ITEM_WIDTH,
    localparam int  SOF_W           = mvb2mfb_pkg::sof_pos_bits(MFB_REGION_SIZE),
    localparam int  EOF_W           = mvb2mfb_pkg::eof_pos_bits(MFB_REGION_SIZE,
                                                                MFB_BLOCK_SIZE)
) (
    input  wire logic                          CLK,
    input  wire logic                          rst,

    // MVB input
    input  wire logic [MVB_ITEMS*ITEM_W-1:0]     rx_mvb_data,
    input  wire logic [MVB_ITEMS*META_WIDTH-1:0] rx_mvb_meta,
    input  wire logic [MVB_ITEMS-1:0]            rx_mvb_vld,
    input  wire logic                          rx_mvb_src_rdy,
    output logic                               rx_mvb_dst_rdy,

    // MFB output
    output logic [MFB_REGIONS*ITEM_W-1:0]      tx_mfb_data,
    output logic [MFB_REGIONS*META_WIDTH-1:0]  tx_mfb_meta,
    output logic [MFB_REGIONS*SOF_W-1:0]       tx_mfb_sof_pos,
    output logic [MFB_REGIONS*EOF_W-1:0]       tx_mfb_eof_pos,
    output logic [MFB_REGIONS-1:0]             tx_mfb_sof,
    output logic [MFB_REGIONS-1:0]             tx_mfb_eof,
    output logic                               tx_mfb_src_rdy,
    input  wire logic                          tx_mfb_dst_rdy
);

    typedef logic [ITEM_W-1:0]     data_item_t;
    typedef logic [META_WIDTH-1:0] meta_item_t;

    item_lane_if #(.REGIONS(MFB_REGIONS), .payload_t(data_item_t)) data_lane ();
    item_lane_if #(.REGIONS(MFB_REGIONS), .payload_t(meta_item_t)) meta_lane ();

    // =========================================================================
    // item queues
    // =========================================================================
    mvb_item_queue #(
        .ITEMS     (MVB_ITEMS),
        .REGIONS   (MFB_REGIONS),
        .payload_t (data_item_t)
    ) data_queue (
        .CLK        (CLK),
        .rst        (rst),
        .in_items   (rx_mvb_data),
        .in_vld     (rx_mvb_vld),
        .in_src_rdy (rx_mvb_src_rdy),
        .in_dst_rdy (rx_mvb_dst_rdy),
        .lane       (data_lane.queue)
    );

    // same handshake as data_queue, so its ready is not needed
    mvb_item_queue #(
        .ITEMS     (MVB_ITEMS),
        .REGIONS   (MFB_REGIONS),
        .payload_t (meta_item_t)
    ) meta_queue (
        .CLK        (CLK),
        .rst        (rst),
        .in_items   (rx_mvb_meta),
        .in_vld     (rx_mvb_vld),
        .in_src_rdy (rx_mvb_src_rdy),
        .in_dst_rdy (),
        .lane       (meta_lane.queue)
    );

    // =========================================================================
    // frame assembler
    // =========================================================================
    mfb_frame_assembler #(
        .REGIONS     (MFB_REGIONS),
        .REGION_SIZE (MFB_REGION_SIZE),
        .BLOCK_SIZE  (MFB_BLOCK_SIZE),
        .ITEM_WIDTH  (MFB_ITEM_WIDTH),
        .META_WIDTH  (META_WIDTH)
    ) assembler (
        .CLK            (CLK),
        .rst            (rst),
        .data_lane      (data_lane.assembler),
        .meta_lane      (meta_lane.assembler),
        .tx_mfb_data    (tx_mfb_data),
        .tx_mfb_meta    (tx_mfb_meta),
        .tx_mfb_sof_pos (tx_mfb_sof_pos),
        .tx_mfb_eof_pos (tx_mfb_eof_pos),
        .tx_mfb_sof     (tx_mfb_sof),
        .tx_mfb_eof     (tx_mfb_eof),
        .tx_mfb_src_rdy (tx_mfb_src_rdy),
        .tx_mfb_dst_rdy (tx_mfb_dst_rdy)
    );

endmodule

`default_nettype wire

// ==== design/mfb_frame_assembler.sv ====
// MFB frame assembler
// packs the data and metadata lanes into registered MFB words with one
// single-region frame per valid item
`timescale 1ns/10ps
`default_nettype none

module mfb_frame_assembler #(
    parameter int REGIONS     = mvb2mfb_pkg::MFB_REGIONS,
    parameter int REGION_SIZE = mvb2mfb_pkg::MFB_REGION_SIZE,
    parameter int BLOCK_SIZE  = mvb2mfb_pkg::MFB_BLOCK_SIZE,
    parameter int ITEM_WIDTH  = mvb2mfb_pkg::MFB_ITEM_WIDTH,
    parameter int META_WIDTH  = mvb2mfb_pkg::META_WIDTH
) (
    input  wire logic CLK,
    input  wire logic rst,

    item_lane_if.assembler data_lane,
    item_lane_if.assembler meta_lane,

    output logic [REGIONS*REGION_SIZE*BLOCK_SIZE*ITEM_WIDTH-1:0]             tx_mfb_data,
    output logic [REGIONS*META_WIDTH-1:0]                                    tx_mfb_meta,
    output logic [REGIONS*mvb2mfb_pkg::sof_pos_bits(REGION_SIZE)-1:0]        tx_mfb_sof_pos,
    output logic [REGIONS*mvb2mfb_pkg::eof_pos_bits(REGION_SIZE, BLOCK_SIZE)-1:0]
                                                                             tx_mfb_eof_pos,
    output logic [REGIONS-1:0]                                               tx_mfb_sof,
    output logic [REGIONS-1:0]                                               tx_mfb_eof,
    output logic                                                             tx_mfb_src_rdy,
    input  wire logic                                                        tx_mfb_dst_rdy
);

    import mvb2mfb_pkg::*;

    localparam int REGION_W   = REGION_SIZE * BLOCK_SIZE * ITEM_WIDTH;
    localparam int SOF_W      = sof_pos_bits(REGION_SIZE);
    localparam int EOF_W      = eof_pos_bits(REGION_SIZE, BLOCK_SIZE);
    localparam int LAST_ITEM  = REGION_SIZE * BLOCK_SIZE - 1;

    logic [REGIONS*REGION_W-1:0]   data_q;
    logic [REGIONS*META_WIDTH-1:0] meta_q;
    logic [REGIONS-1:0]            vld_q;
    logic                          full_q;

    logic                          load;

    // =========================================================================
    // output register and back-pressure
    // =========================================================================
    // register takes a new word when empty or drained this cycle
    assign load = !full_q || tx_mfb_dst_rdy;

    assign data_lane.dst_rdy = load;
    assign meta_lane.dst_rdy = load;

    always_ff @(posedge CLK) begin
        if (rst) begin
            full_q <= 1'b0;
            vld_q  <= '0;
        end else if (load) begin
            full_q <= data_lane.src_rdy;
            vld_q  <= data_lane.src_rdy ? data_lane.vld : '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (load && data_lane.src_rdy) begin
            data_q <= data_lane.payload;
            meta_q <= meta_lane.payload;
        end
    end

    // =========================================================================
    // frame markers
    // =========================================================================
    // every item is a whole frame, so sof and eof coincide
    assign tx_mfb_sof     = vld_q;
    assign tx_mfb_eof     = vld_q;
    assign tx_mfb_data    = data_q;
    assign tx_mfb_meta    = meta_q;
    assign tx_mfb_src_rdy = full_q;

    for (genvar r = 0; r < REGIONS; r++) begin : g_pos
        assign tx_mfb_sof_pos[r*SOF_W +: SOF_W] = '0;
        assign tx_mfb_eof_pos[r*EOF_W +: EOF_W] = EOF_W'(LAST_ITEM);
    end

    // =========================================================================
    // assertions
    // =========================================================================
    // both queues must advance in lockstep
    assert property (@(posedge CLK) disable iff (rst)
        (data_lane.src_rdy == meta_lane.src_rdy) && (data_lane.vld == meta_lane.vld))
        else $error("frame assembler: data and metadata lanes out of step");

    assert property (@(posedge CLK) disable iff (rst)
        (tx_mfb_src_rdy && !tx_mfb_dst_rdy) |=>
            (tx_mfb_src_rdy && $stable(tx_mfb_data) && $stable(tx_mfb_meta)
             && $stable(tx_mfb_sof)))
        else $error("frame assembler: output word changed while stalled");

endmodule

`default_nettype wire

// ==== design/mvb_item_queue.sv ====
// MVB item queue
// holds one input word and hands out its valid items in index order,
// up to REGIONS items per lane transfer
`timescale 1ns/10ps
`default_nettype none

module mvb_item_queue #(
    parameter int  ITEMS     = mvb2mfb_pkg::MVB_ITEMS,
    parameter int  REGIONS   = mvb2mfb_pkg::MFB_REGIONS,
    parameter type payload_t = logic [mvb2mfb_pkg::item_width-1:0]
) (
    input  wire logic                   CLK,
    input  wire logic                   rst,

    input  wire payload_t [ITEMS-1:0]   in_items,
    input  wire logic     [ITEMS-1:0]   in_vld,
    input  wire logic                   in_src_rdy,
    output logic                        in_dst_rdy,

    item_lane_if.queue                  lane
);

    localparam int IDX_W = (ITEMS > 1) ? $clog2(ITEMS) : 1;

    payload_t [ITEMS-1:0] items_q;
    logic     [ITEMS-1:0] mask_q;

    logic     [ITEMS-1:0] take_mask;
    logic     [ITEMS-1:0] rest_mask;
    logic     [REGIONS-1:0] sel_vld;
    logic     [IDX_W-1:0] sel_idx [REGIONS];

    logic                 lane_xfer;
    logic                 in_accept;

    // =========================================================================
    // item selection
    // =========================================================================
    // first REGIONS pending items, lowest index first
    always_comb begin : select_items
        int slot;
        slot      = 0;
        sel_vld   = '0;
        take_mask = '0;
        for (int r = 0; r < REGIONS; r++) begin
            sel_idx[r] = '0;
        end
        for (int i = 0; i < ITEMS; i++) begin
            if (mask_q[i] && slot < REGIONS) begin
                sel_vld[slot] = 1'b1;
                sel_idx[slot] = IDX_W'(i);
                take_mask[i]  = 1'b1;
                slot          = slot + 1;
            end
        end
    end

    for (genvar r = 0; r < REGIONS; r++) begin : g_region
        assign lane.payload[r] = items_q[sel_idx[r]];
    end

    assign lane.vld     = sel_vld;
    assign lane.src_rdy = |mask_q;

    assign rest_mask = mask_q & ~take_mask;
    assign lane_xfer = lane.src_rdy && lane.dst_rdy;

    // empty now, or the last items go out this cycle
    assign in_dst_rdy = !(|mask_q) || (lane_xfer && rest_mask == '0);
    assign in_accept  = in_src_rdy && in_dst_rdy;

    // =========================================================================
    // word storage
    // =========================================================================
    always_ff @(posedge CLK) begin
        if (rst) begin
            mask_q <= '0;
        end else if (in_accept) begin
            // an all-zero mask drops the word here
            mask_q <= in_vld;
        end else if (lane_xfer) begin
            mask_q <= rest_mask;
        end
    end

    always_ff @(posedge CLK) begin
        if (in_accept) begin
            items_q <= in_items;
        end
    end

    // =========================================================================
    // assertions
    // =========================================================================
    // valid regions are packed from region 0 upward
    assert property (@(posedge CLK) disable iff (rst)
        (lane.vld & (lane.vld + 1'b1)) == '0)
        else $error("item queue: lane vld has a gap");

    assert property (@(posedge CLK) disable iff (rst)
        lane.src_rdy |-> (|lane.vld))
        else $error("item queue: src_rdy without a valid region");

endmodule

`default_nettype wire

// ==== design/item_lane_if.sv ====
// Item lane between an item queue and the frame assembler
// carries up to REGIONS compacted items per cycle, lowest region first
`timescale 1ns/10ps
`default_nettype none

interface item_lane_if #(
    parameter int  REGIONS   = mvb2mfb_pkg::MFB_REGIONS,
    parameter type payload_t = logic [mvb2mfb_pkg::item_width-1:0]
);

    payload_t [REGIONS-1:0] payload;
    logic     [REGIONS-1:0] vld;
    logic                   src_rdy;
    logic                   dst_rdy;

    modport queue (
        output payload,
        output vld,
        output src_rdy,
        input  dst_rdy
    );

    modport assembler (
        input  payload,
        input  vld,
        input  src_rdy,
        output dst_rdy
    );

endinterface

`default_nettype wire

// ==== design/mvb2mfb_pkg.sv ====
// MVB to MFB converter shared definitions
// default bus geometry and the widths that follow from it
`default_nettype none

package mvb2mfb_pkg;

    // =========================================================================
    // bus geometry defaults
    // =========================================================================
    parameter int MVB_ITEMS       = 4;
    parameter int MFB_REGIONS     = 2;
    parameter int MFB_REGION_SIZE = 2;
    parameter int MFB_BLOCK_SIZE  = 4;
    parameter int MFB_ITEM_WIDTH  = 8;
    parameter int META_WIDTH      = 8;

    // =========================================================================
    // derived widths
    // =========================================================================
    // start position selects a block inside a region
    function automatic int sof_pos_bits(int region_size);
        return (region_size > 1) ? $clog2(region_size) : 1;
    endfunction

    // end position selects an item inside a region
    function automatic int eof_pos_bits(int region_size, int block_size);
        return (region_size * block_size > 1) ? $clog2(region_size * block_size) : 1;
    endfunction

    // one MVB item fills one whole region
    parameter int item_width    = MFB_REGION_SIZE * MFB_BLOCK_SIZE * MFB_ITEM_WIDTH;
    parameter int sof_pos_width = sof_pos_bits(MFB_REGION_SIZE);
    parameter int eof_pos_width = eof_pos_bits(MFB_REGION_SIZE, MFB_BLOCK_SIZE);

endpackage

`default_nettype wire
